// ==== hdl/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// ------------------------------
// Address map
// ------------------------------
`define UART_BASE_ADDR        16'h0200       // Upper address half selecting the UART

// Byte offsets, word aligned
`define UART_TX_OFS           4'h0           // Transmit data, write only
`define UART_STATUS_OFS       4'h4           // Status, read clears overrun
`define UART_RX_OFS           4'h8           // Receive data, read pops FIFO
`define UART_BAUD_OFS         4'hC           // Clocks per bit, lanes 0 and 1

// ------------------------------
// Sizing and reset values
// ------------------------------
`define UART_RX_DEPTH         4              // Receive FIFO entries
`define UART_DEFAULT_PRESCALE 16'd16         // Clocks per bit after reset

// Returned by a receive read with nothing waiting
`define UART_RX_EMPTY_WORD    32'hFFFF_FF00

`endif

// ==== hdl/uart_pkg.sv ====
`include "uart_params.svh"

package uart_pkg;

    // ------------------------------
    // Memory bus
    // ------------------------------
    typedef struct packed {
        logic        valid;     // Request pending
        logic [31:0] addr;      // Byte address
        logic [31:0] wdata;
        logic [3:0]  wstrb;     // Any lane set means write
    } mem_req_t;                // 69 bits

    typedef struct packed {
        logic        ready;     // One cycle, completes the request
        logic [31:0] rdata;
    } mem_rsp_t;                // 33 bits

    // ------------------------------
    // UART data and status
    // ------------------------------
    typedef logic [7:0] uart_byte_t;

    // First member lands in the top bit, so bit 0 is rx_avail
    typedef struct packed {
        logic rx_overrun;       // Bit 3, sticky
        logic tx_busy;          // Bit 2
        logic rx_full;          // Bit 1
        logic rx_avail;         // Bit 0
    } uart_status_t;

    // Register offsets within the 16-byte window
    typedef enum logic [3:0] {
        REG_TX     = `UART_TX_OFS,
        REG_STATUS = `UART_STATUS_OFS,
        REG_RX     = `UART_RX_OFS,
        REG_BAUD   = `UART_BAUD_OFS
    } reg_ofs_e;

    // Serializer and deserializer phases
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// ==== hdl/uart_fifo.sv ====
module uart_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full,
    output logic             overrun      // Pulse when a push is refused
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                // Occupancy
    logic             do_push;
    logic             do_pop;

    // Wrap at DEPTH, works for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = push && !full;         // Byte dropped when full
    assign do_pop  = pop && !empty;         // Pop on empty ignored
    assign head    = mem[rd_ptr];           // Oldest entry, visible without a pop

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            overrun <= push && full;
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                  // Both or neither, count holds
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// ==== hdl/uart_tx.sv ====
module uart_tx import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] prescale,       // Clocks per bit
    input  logic        tx_start,       // One-cycle request, only honored when idle
    input  uart_byte_t  tx_data,
    output logic        txd,
    output logic        tx_busy
);

    tx_state_e   state;
    logic [15:0] bit_cnt;               // Clocks into current bit
    logic [2:0]  bit_idx;               // Data bit being sent
    uart_byte_t  shreg;                 // Remaining data bits, LSB goes next
    logic        bit_end;

    assign bit_end = (bit_cnt == prescale - 16'd1);
    assign tx_busy = (state != TX_IDLE);

    // ------------------------------
    // Frame sequencer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            txd     <= 1'b1;            // Line idles high
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            bit_cnt <= bit_end ? '0 : bit_cnt + 16'd1;
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    if (tx_start) begin
                        state <= TX_START;
                        txd   <= 1'b0;  // Start bit
                    end
                end
                TX_START: if (bit_end) begin
                    state   <= TX_DATA;
                    txd     <= shreg[0];
                    bit_idx <= '0;
                end
                TX_DATA: if (bit_end) begin
                    if (bit_idx == 3'd7) begin
                        state <= TX_STOP;
                        txd   <= 1'b1;  // Stop bit
                    end else begin
                        txd     <= shreg[1];
                        bit_idx <= bit_idx + 3'd1;
                    end
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte captured at start, then shifted once per data bit
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shreg <= tx_data;
        end else if (state == TX_DATA && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

// ==== hdl/uart_rx.sv ====
module uart_rx import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] prescale,       // Clocks per bit
    input  logic        rxd,            // Asynchronous serial input
    output uart_byte_t  rx_data,        // Valid with rx_strobe
    output logic        rx_strobe
);

    rx_state_e   state;
    logic [1:0]  sync;                  // Metastability stages
    logic        rxd_s;                 // Synchronized line
    logic        rxd_d;                 // Previous value for edge detect
    logic [15:0] bit_cnt;
    logic [2:0]  bit_idx;
    logic        half_end;
    logic        bit_end;

    assign rxd_s    = sync[1];
    assign half_end = (bit_cnt == (prescale >> 1) - 16'd1);    // Middle of start bit
    assign bit_end  = (bit_cnt == prescale - 16'd1);           // Middle of later bits

    // ------------------------------
    // Input synchronizer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync  <= 2'b11;
            rxd_d <= 1'b1;
        end else begin
            sync  <= {sync[0], rxd};
            rxd_d <= rxd_s;
        end
    end

    // ------------------------------
    // Frame sampler
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            bit_cnt   <= bit_cnt + 16'd1;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (rxd_d && !rxd_s) state <= RX_START;     // Falling edge
                end
                RX_START: if (half_end) begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    // Line back high means a glitch, not a start bit
                    state   <= rxd_s ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (bit_end) begin
                    bit_cnt <= '0;
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (bit_end) begin
                    state     <= RX_IDLE;
                    rx_strobe <= rxd_s;             // Bad stop bit drops the frame
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data shifts in LSB first, holds until the next frame
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) rx_data <= {rxd_s, rx_data[7:1]};
    end

endmodule

// ==== hdl/uart_regs.sv ====
`include "uart_params.svh"

module uart_regs import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  mem_req_t    bus_req,
    output mem_rsp_t    bus_rsp,
    input  logic        tx_busy,
    output logic        tx_start,       // One-cycle send request
    output uart_byte_t  tx_data,
    input  uart_byte_t  rx_head,
    input  logic        rx_empty,
    input  logic        rx_full,
    input  logic        rx_overrun,     // FIFO refused a byte
    output logic        rx_pop,         // One-cycle, with the read response
    output logic [15:0] prescale
);

    logic         rsp_ready;
    logic [31:0]  rsp_rdata;
    logic         ready_d;              // Guard cycle after ready
    logic         tx_wait;              // Transmit write stalled on busy
    logic         overrun_flag;         // Sticky until status read
    logic         sel;
    logic         is_write;
    logic         accept;
    reg_ofs_e     ofs;
    uart_status_t status;

    // ------------------------------
    // Decode
    // ------------------------------
    assign sel      = bus_req.valid && (bus_req.addr[31:16] == `UART_BASE_ADDR);
    assign is_write = |bus_req.wstrb;
    assign ofs      = reg_ofs_e'(bus_req.addr[3:0]);
    // Not while answering, in the guard cycle, or stalled
    assign accept   = sel && !rsp_ready && !ready_d && !tx_wait;

    assign status = '{rx_overrun: overrun_flag,
                      tx_busy:    tx_busy,
                      rx_full:    rx_full,
                      rx_avail:   !rx_empty};

    assign bus_rsp = '{ready: rsp_ready, rdata: rsp_rdata};

    // ------------------------------
    // Control and configuration
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_ready    <= 1'b0;
            ready_d      <= 1'b0;
            tx_wait      <= 1'b0;
            tx_start     <= 1'b0;
            rx_pop       <= 1'b0;
            overrun_flag <= 1'b0;
            prescale     <= `UART_DEFAULT_PRESCALE;
        end else begin
            rsp_ready <= 1'b0;          // Strobes default low
            tx_start  <= 1'b0;
            rx_pop    <= 1'b0;
            ready_d   <= rsp_ready;
            if (tx_wait) begin
                if (!tx_busy) begin     // Transmitter freed, release the write
                    tx_wait   <= 1'b0;
                    tx_start  <= 1'b1;
                    rsp_ready <= 1'b1;
                end
            end else if (accept) begin
                case (ofs)
                    REG_TX: begin
                        if (is_write && tx_busy) begin
                            tx_wait <= 1'b1;            // Stall the bus
                        end else begin
                            tx_start  <= is_write;
                            rsp_ready <= 1'b1;
                        end
                    end
                    REG_STATUS: begin
                        rsp_ready <= 1'b1;
                        if (!is_write) overrun_flag <= 1'b0;
                    end
                    REG_RX: begin
                        rsp_ready <= 1'b1;
                        rx_pop    <= !is_write && !rx_empty;
                    end
                    REG_BAUD: begin
                        rsp_ready <= 1'b1;
                        if (bus_req.wstrb[0]) prescale[7:0]  <= bus_req.wdata[7:0];
                        if (bus_req.wstrb[1]) prescale[15:8] <= bus_req.wdata[15:8];
                    end
                    default: rsp_ready <= 1'b1;         // Unknown offset, answer zero
                endcase
            end
            // A new overrun wins over a clearing read
            if (rx_overrun) overrun_flag <= 1'b1;
        end
    end

    // ------------------------------
    // Read data and transmit byte
    // ------------------------------
    always_ff @(posedge clk) begin
        rsp_rdata <= '0;
        if (accept && !is_write) begin
            case (ofs)
                REG_STATUS: rsp_rdata <= {28'd0, status};
                REG_RX:     rsp_rdata <= rx_empty ? `UART_RX_EMPTY_WORD : {24'd0, rx_head};
                default:    ;
            endcase
        end
        if (accept && is_write && ofs == REG_TX && bus_req.wstrb[0]) begin
            tx_data <= bus_req.wdata[7:0];  // Held through any stall
        end
    end

endmodule

// ==== hdl/uart_periph.sv ====
`include "uart_params.svh"

module uart_periph import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rxd,
    output logic        txd,
    input  mem_req_t    bus_req,
    output mem_rsp_t    bus_rsp,
    output logic        irq_rx_valid,   // Level, data waiting in FIFO
    output logic [15:0] prescale_out
);

    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_busy;
    uart_byte_t rx_data;
    logic       rx_strobe;
    logic       rx_pop;
    uart_byte_t rx_head;
    logic       rx_empty;
    logic       rx_full;
    logic       rx_overrun;

    assign irq_rx_valid = !rx_empty;

    // ------------------------------
    // Register block
    // ------------------------------
    uart_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .rx_head    (rx_head),
        .rx_empty   (rx_empty),
        .rx_full    (rx_full),
        .rx_overrun (rx_overrun),
        .rx_pop     (rx_pop),
        .prescale   (prescale_out)      // Also sets the bit time of both directions
    );

    // ------------------------------
    // Serial side
    // ------------------------------
    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .prescale (prescale_out),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .prescale  (prescale_out),
        .rxd       (rxd),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe)
    );

    // Receive buffer between deserializer and bus
    uart_fifo #(
        .WIDTH (8),
        .DEPTH (`UART_RX_DEPTH)
    ) u_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_strobe),
        .push_data (rx_data),
        .pop       (rx_pop),
        .head      (rx_head),
        .empty     (rx_empty),
        .full      (rx_full),
        .overrun   (rx_overrun)
    );

endmodule

// ==== sim/tb_uart_periph.sv ====
`include "uart_params.svh"

module tb_uart_periph import uart_pkg::*; ();

    localparam int NUM_TX         = 20;
    localparam int NUM_FRAMES     = NUM_TX + `UART_RX_DEPTH + (`UART_RX_DEPTH + 2);
    localparam int MAX_PRESCALE   = 24;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 10 * MAX_PRESCALE * 3 + 2000;

    logic        clk;
    logic        rst_n;
    logic        rxd;
    logic        txd;
    mem_req_t    bus_req;
    mem_rsp_t    bus_rsp;
    logic        irq_rx_valid;
    logic [15:0] prescale_out;

    int          seed = 41;
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    logic [31:0] rnd;
    logic [31:0] rdata;
    logic [15:0] cur_prescale;          // Model copy of the bit period
    uart_byte_t  tx_expect[$];          // Bytes written to the transmit register
    uart_byte_t  tx_seen[$];            // Bytes recovered from txd
    uart_byte_t  rx_model[$];           // Expected receive FIFO contents
    logic        ovr_model;             // Expected sticky overrun

    uart_periph UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .rxd          (rxd),
        .txd          (txd),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .irq_rx_valid (irq_rx_valid),
        .prescale_out (prescale_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input uart_status_t got, input uart_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: status got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_prescale(input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: prescale_out got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_line(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // Bus master
    // ------------------------------
    // Starts 1 unit after an edge and holds the request until ready
    task automatic bus_cycle(input logic [3:0] ofs, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] data);
        bus_req.valid = 1'b1;
        bus_req.addr  = {`UART_BASE_ADDR, 12'h000, ofs};
        bus_req.wdata = wdata;
        bus_req.wstrb = wstrb;
        do begin
            @(posedge clk);
            #1;
        end while (!bus_rsp.ready);
        data    = bus_rsp.rdata;
        bus_req = '0;                   // Drop the request once ready is seen
    endtask

    task automatic bus_write(input logic [3:0] ofs, input logic [31:0] wdata,
                             output logic [31:0] data);
        bus_cycle(ofs, wdata, 4'hF, data);
    endtask

    task automatic bus_read(input logic [3:0] ofs, output logic [31:0] data);
        bus_cycle(ofs, 32'd0, 4'h0, data);
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic uart_status_t expect_status(input logic busy);
        uart_status_t s;
        s.rx_avail   = (rx_model.size() != 0);
        s.rx_full    = (rx_model.size() == `UART_RX_DEPTH);
        s.tx_busy    = busy;
        s.rx_overrun = ovr_model;
        return s;
    endfunction

    task automatic model_rx_push(input uart_byte_t b);
        if (rx_model.size() < `UART_RX_DEPTH) rx_model.push_back(b);
        else ovr_model = 1'b1;          // FIFO drops the byte
    endtask

    task automatic read_status_check(input logic busy);
        uart_status_t exp;
        exp = expect_status(busy);
        bus_read(`UART_STATUS_OFS, rdata);
        check_status(rdata[3:0], exp);
        check_word({rdata[31:4], 4'h0}, 32'd0, "status upper bits");
        ovr_model = 1'b0;               // Read clears the sticky flag
    endtask

    // Drives one rxd bit for prescale clocks
    task automatic drive_bit(input logic v);
        rxd = v;
        repeat (cur_prescale) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input uart_byte_t b);
        drive_bit(1'b0);                // Start
        for (int i = 0; i < 8; i++) drive_bit(b[i]);
        drive_bit(1'b1);                // Stop
        drive_bit(1'b1);                // Idle gap
    endtask

    // Samples txd mid-bit with the model's period
    initial begin : txd_monitor
        uart_byte_t b;
        int         p;
        forever begin
            @(negedge txd);
            p = cur_prescale;
            repeat (p / 2) @(posedge clk);
            #1;
            check_line(txd, 1'b0, "txd start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (p) @(posedge clk);
                #1;
                b[i] = txd;
            end
            repeat (p) @(posedge clk);
            #1;
            check_line(txd, 1'b1, "txd stop bit");
            tx_seen.push_back(b);
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : main
        uart_byte_t b;
        int         n;
        rst_n        = 1'b0;
        rxd          = 1'b1;
        bus_req      = '0;
        ovr_model    = 1'b0;
        cur_prescale = `UART_DEFAULT_PRESCALE;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_prescale(prescale_out, `UART_DEFAULT_PRESCALE);
        check_line(txd, 1'b1, "txd after reset");
        check_line(irq_rx_valid, 1'b0, "irq after reset");

        // Random baud values of 8 to 24 with junk in the upper half
        for (int k = 0; k < 4; k++) begin
            rnd          = $random(seed);
            cur_prescale = 16'd8 + {8'd0, rnd[7:0] % 8'd17};
            bus_write(`UART_BAUD_OFS, {rnd[31:16], cur_prescale}, rdata);
            check_word(rdata, 32'd0, "baud write rdata");
            check_prescale(prescale_out, cur_prescale);
        end

        // Back to back transmit writes stall while busy
        for (int k = 0; k < NUM_TX; k++) begin
            rnd = $random(seed);
            b   = rnd[7:0];
            tx_expect.push_back(b);
            bus_write(`UART_TX_OFS, {rnd[31:8], b}, rdata);
            check_word(rdata, 32'd0, "tx write rdata");
            read_status_check(1'b1);
        end
        while (tx_seen.size() < NUM_TX) @(posedge clk);
        for (int k = 0; k < NUM_TX; k++) check_byte(tx_seen[k], tx_expect[k], "txd byte");
        repeat (2 * cur_prescale) @(posedge clk);   // Let the last stop bit end
        #1;

        // Receive up to depth frames
        rnd = $random(seed);
        n   = 1 + int'(rnd[7:0] % 8'(`UART_RX_DEPTH));
        for (int k = 0; k < n; k++) begin
            rnd = $random(seed);
            send_frame(rnd[7:0]);
            model_rx_push(rnd[7:0]);
        end
        check_line(irq_rx_valid, 1'b1, "irq with data waiting");
        while (rx_model.size() != 0) begin
            b = rx_model.pop_front();
            bus_read(`UART_RX_OFS, rdata);
            check_word(rdata, {24'd0, b}, "rx read");
            @(posedge clk);
            #1;
            check_line(irq_rx_valid, rx_model.size() != 0, "irq after pop");
        end

        // Empty receive read
        bus_read(`UART_RX_OFS, rdata);
        check_word(rdata, `UART_RX_EMPTY_WORD, "empty rx read");
        read_status_check(1'b0);

        // Overflow with depth plus two frames unread
        for (int k = 0; k < `UART_RX_DEPTH + 2; k++) begin
            rnd = $random(seed);
            send_frame(rnd[7:0]);
            model_rx_push(rnd[7:0]);
        end
        read_status_check(1'b0);        // Full and overrun
        read_status_check(1'b0);        // Overrun now clear
        while (rx_model.size() != 0) begin
            b = rx_model.pop_front();
            bus_read(`UART_RX_OFS, rdata);
            check_word(rdata, {24'd0, b}, "rx read after overrun");
        end
        bus_read(`UART_RX_OFS, rdata);
        check_word(rdata, `UART_RX_EMPTY_WORD, "rx read past depth");

        // Only the written bytes may ever appear on txd
        check_word(32'(tx_seen.size()), NUM_TX, "txd frame count");

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/uart_periph.sv
sim/tb_uart_periph.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart_periph
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
